/* logic/regs_pkg.sv */
`default_nettype none

package regs_pkg;

    // unified register address
    // 0-31 gpr, 32-63 cp0, 64 lo, 127 hi
    typedef logic [6:0] reg_addr_t;

    typedef enum logic [2:0] {
        region_gpr,
        region_cp0,
        region_lo,
        region_hi,
        region_none
    } reg_region_e;

    // implemented cp0 register numbers
    typedef enum logic [4:0] {
        cp0_badvaddr = 5'd8,
        cp0_status   = 5'd12,
        cp0_cause    = 5'd13,
        cp0_epc      = 5'd14,
        cp0_prid     = 5'd15
    } cp0_sel_e;

    // excode values for cause[6:2]
    typedef enum logic [4:0] {
        exc_int  = 5'd0,
        exc_adel = 5'd4,
        exc_ades = 5'd5,
        exc_sys  = 5'd8,
        exc_bp   = 5'd9,
        exc_ri   = 5'd10,
        exc_ov   = 5'd12
    } exc_code_e;

    // write-back port, one word
    typedef struct packed {
        logic        en;
        reg_addr_t   addr;
        logic [31:0] data;
    } wb_write_t;

    // mult/div result, both halves at once
    typedef struct packed {
        logic        en;
        logic [31:0] hi;
        logic [31:0] lo;
    } hilo_write_t;

    // exception being committed this cycle
    typedef struct packed {
        logic        valid;
        exc_code_e   code;
        logic [31:0] epc;
        logic [31:0] badaddr;
        logic        branch_delay;
    } exc_event_t;

    // cp0 state seen by the exception logic
    typedef struct packed {
        logic [31:0] status;
        logic [31:0] cause;
        logic [31:0] epc;
    } cp0_view_t;

    // address to region
    // 65-126 store nothing
    function automatic reg_region_e region_of(input reg_addr_t addr);
        reg_region_e region;
        if (!addr[6]) begin
            if (addr[5]) begin
                region = region_cp0;
            end else begin
                region = region_gpr;
            end
        end else if (addr == 7'd64) begin
            region = region_lo;
        end else if (addr == 7'd127) begin
            region = region_hi;
        end else begin
            region = region_none;
        end
        return region;
    endfunction

endpackage

`default_nettype wire

/* logic/gpr_bank.sv */
`timescale 1ns/10ps
`default_nettype none

module gpr_bank (
    input  logic        clk,
    input  logic        we,
    input  logic [4:0]  waddr,
    input  logic [31:0] wdata,
    input  logic [4:0]  raddr_1,
    input  logic [4:0]  raddr_2,
    output logic [31:0] rdata_1,
    output logic [31:0] rdata_2
);

    // r1..r31 only
    // r0 has no storage at all
    logic [31:0] regs [1:31];

    // write port
    // top already masks r0, the check here keeps the index in range
    always_ff @(posedge clk) begin
        if (we && waddr != 5'd0) begin
            regs[waddr] <= wdata;
        end
    end

    // read port 1
    // r0 always zero
    always_comb begin
        if (raddr_1 == 5'd0) begin
            rdata_1 = '0;
        end else begin
            rdata_1 = regs[raddr_1];
        end
    end

    // read port 2
    // same as port 1
    always_comb begin
        if (raddr_2 == 5'd0) begin
            rdata_2 = '0;
        end else begin
            rdata_2 = regs[raddr_2];
        end
    end

    // no same-cycle bypass here
    // operand_read forwards wb data

endmodule

`default_nettype wire

/* logic/hilo_regs.sv */
`timescale 1ns/10ps
`default_nettype none

module hilo_regs (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  we,
    input  logic                  sel_hi,
    input  logic [31:0]           wdata,
    input  regs_pkg::hilo_write_t bulk,
    output logic [31:0]           hi,
    output logic [31:0]           lo
);

    // hi register
    // bulk result beats mthi
    always_ff @(posedge clk) begin
        if (reset) begin
            hi <= '0;
        end else if (bulk.en) begin
            hi <= bulk.hi;
        end else if (we && sel_hi) begin
            hi <= wdata;
        end
    end

    // lo register
    // bulk result beats mtlo
    always_ff @(posedge clk) begin
        if (reset) begin
            lo <= '0;
        end else if (bulk.en) begin
            lo <= bulk.lo;
        end else if (we && !sel_hi) begin
            lo <= wdata;
        end
    end

    // single-word write touches one half only
    // a bulk write replaces both in one edge

endmodule

`default_nettype wire

/* logic/cp0_regs.sv */
`timescale 1ns/10ps
`default_nettype none

module cp0_regs #(
    parameter logic [31:0] STATUS_RESET = 32'h0040_0000,
    parameter logic [31:0] PRID_VALUE   = 32'h0000_4220
) (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 we,
    input  logic [4:0]           waddr,
    input  logic [31:0]          wdata,
    input  logic [4:0]           raddr,
    output logic [31:0]          rdata,
    input  regs_pkg::exc_event_t exc,
    input  logic                 eret,
    input  logic [5:0]           hw_int,
    output regs_pkg::cp0_view_t  view,
    output logic                 allow_interrupt
);
    import regs_pkg::*;

    // im 15:8, exl 1, ie 0
    localparam logic [31:0] STATUS_WMASK = 32'h0000_ff03;

    logic [31:0] badvaddr_q;
    logic [31:0] status_q;
    logic [31:0] cause_q;
    logic [31:0] epc_q;

    cp0_sel_e wsel;
    cp0_sel_e rsel;

    logic wr_status;
    logic wr_cause;
    logic wr_epc;
    logic wr_badvaddr;
    logic addr_exc;

    assign wsel = cp0_sel_e'(waddr);
    assign rsel = cp0_sel_e'(raddr);

    // mtc0 strobes per register
    // prid has none, read-only
    assign wr_status   = we && (wsel == cp0_status);
    assign wr_cause    = we && (wsel == cp0_cause);
    assign wr_epc      = we && (wsel == cp0_epc);
    assign wr_badvaddr = we && (wsel == cp0_badvaddr);

    // only address errors load badvaddr
    assign addr_exc = exc.valid && (exc.code == exc_adel || exc.code == exc_ades);

    // status
    // exception > eret > mtc0
    always_ff @(posedge clk) begin
        if (reset) begin
            status_q <= STATUS_RESET;
        end else if (exc.valid) begin
            status_q[1] <= 1'b1;
        end else if (eret) begin
            status_q[1] <= 1'b0;
        end else if (wr_status) begin
            status_q <= (status_q & ~STATUS_WMASK) | (wdata & STATUS_WMASK);
        end
    end

    // cause
    // ip 15:10 follow the pins, one cycle late
    // software may only set ip 9:8
    always_ff @(posedge clk) begin
        if (reset) begin
            cause_q <= '0;
        end else begin
            cause_q[15:10] <= hw_int;
            if (exc.valid) begin
                cause_q[31]  <= exc.branch_delay;
                cause_q[6:2] <= exc.code;
            end else if (wr_cause) begin
                cause_q[9:8] <= wdata[9:8];
            end
        end
    end

    // epc
    // exception wins over mtc0
    always_ff @(posedge clk) begin
        if (reset) begin
            epc_q <= '0;
        end else if (exc.valid) begin
            epc_q <= exc.epc;
        end else if (wr_epc) begin
            epc_q <= wdata;
        end
    end

    // badvaddr
    // a non-address exception leaves it to mtc0
    always_ff @(posedge clk) begin
        if (reset) begin
            badvaddr_q <= '0;
        end else if (addr_exc) begin
            badvaddr_q <= exc.badaddr;
        end else if (wr_badvaddr) begin
            badvaddr_q <= wdata;
        end
    end

    // read mux
    // unimplemented numbers read zero
    always_comb begin
        case (rsel)
            cp0_badvaddr: rdata = badvaddr_q;
            cp0_status:   rdata = status_q;
            cp0_cause:    rdata = cause_q;
            cp0_epc:      rdata = epc_q;
            cp0_prid:     rdata = PRID_VALUE;
            default:      rdata = '0;
        endcase
    end

    assign view.status = status_q;
    assign view.cause  = cause_q;
    assign view.epc    = epc_q;

    // ie set, exl clear, some pending ip unmasked
    assign allow_interrupt = status_q[0] && !status_q[1]
                             && |(cause_q[15:8] & status_q[15:8]);

endmodule

`default_nettype wire

/* logic/operand_read.sv */
`timescale 1ns/10ps
`default_nettype none

module operand_read #(
    parameter bit CP0_VISIBLE = 1'b0
) (
    input  regs_pkg::reg_addr_t   raddr,
    input  regs_pkg::reg_region_e region,
    input  regs_pkg::wb_write_t   wb,
    input  regs_pkg::hilo_write_t hilo_wr,
    input  logic [31:0]           gpr_data,
    input  logic [31:0]           hi,
    input  logic [31:0]           lo,
    input  logic [31:0]           cp0_data,
    output logic [31:0]           rdata
);
    import regs_pkg::*;

    logic wb_hit;
    logic hilo_hit;

    // same-cycle write-back to this address
    // r0 never forwarded
    assign wb_hit = wb.en && (wb.addr == raddr) && (raddr != '0);

    // bulk mult/div result, hi or lo only
    assign hilo_hit = hilo_wr.en && (region == region_hi || region == region_lo);

    // first match wins
    always_comb begin
        if (wb_hit) begin
            rdata = wb.data;
        end else if (hilo_hit) begin
            if (region == region_hi) begin
                rdata = hilo_wr.hi;
            end else begin
                rdata = hilo_wr.lo;
            end
        end else begin
            // stored state
            case (region)
                region_gpr: rdata = gpr_data;
                region_cp0: begin
                    // only port 2 sees cp0
                    if (CP0_VISIBLE) begin
                        rdata = cp0_data;
                    end else begin
                        rdata = '0;
                    end
                end
                region_hi:  rdata = hi;
                region_lo:  rdata = lo;
                // unused 65-126 fall back to lo
                default:    rdata = lo;
            endcase
        end
    end

    // gpr_data is already zero for r0
    // so no extra check in the gpr arm

endmodule

`default_nettype wire

/* logic/mips_regs_top.sv */
`timescale 1ns/10ps
`default_nettype none

module mips_regs_top #(
    parameter logic [31:0] STATUS_RESET = 32'h0040_0000,
    parameter logic [31:0] PRID_VALUE   = 32'h0000_4220
) (
    input  logic                  clk,
    input  logic                  reset,
    input  regs_pkg::wb_write_t   wb,
    input  regs_pkg::hilo_write_t hilo_wr,
    input  regs_pkg::exc_event_t  exc,
    input  logic                  eret,
    input  logic [5:0]            hw_int,
    input  regs_pkg::reg_addr_t   raddr_1,
    input  regs_pkg::reg_addr_t   raddr_2,
    output logic [31:0]           rdata_1,
    output logic [31:0]           rdata_2,
    output regs_pkg::cp0_view_t   cp0_out,
    output logic                  allow_interrupt
);
    import regs_pkg::*;

    reg_region_e wr_region;
    reg_region_e rd_region_1;
    reg_region_e rd_region_2;

    logic gpr_we;
    logic hilo_we;
    logic cp0_we;

    logic [31:0] gpr_rdata_1;
    logic [31:0] gpr_rdata_2;
    logic [31:0] hi_q;
    logic [31:0] lo_q;
    logic [31:0] cp0_rdata;

    // one write decode, shared by all banks
    assign wr_region   = region_of(wb.addr);
    assign rd_region_1 = region_of(raddr_1);
    assign rd_region_2 = region_of(raddr_2);

    // per-bank write enables
    // writes to 65-126 are dropped
    assign gpr_we  = wb.en && (wr_region == region_gpr) && (wb.addr[4:0] != 5'd0);
    assign hilo_we = wb.en && (wr_region == region_lo || wr_region == region_hi);
    assign cp0_we  = wb.en && (wr_region == region_cp0);

    gpr_bank gpr_bank_inst (
        .clk     (clk),
        .we      (gpr_we),
        .waddr   (wb.addr[4:0]),
        .wdata   (wb.data),
        .raddr_1 (raddr_1[4:0]),
        .raddr_2 (raddr_2[4:0]),
        .rdata_1 (gpr_rdata_1),
        .rdata_2 (gpr_rdata_2)
    );

    hilo_regs hilo_regs_inst (
        .clk    (clk),
        .reset  (reset),
        .we     (hilo_we),
        .sel_hi (wr_region == region_hi),
        .wdata  (wb.data),
        .bulk   (hilo_wr),
        .hi     (hi_q),
        .lo     (lo_q)
    );

    // cp0 read address comes from port 2 only
    cp0_regs #(
        .STATUS_RESET (STATUS_RESET),
        .PRID_VALUE   (PRID_VALUE)
    ) cp0_regs_inst (
        .clk             (clk),
        .reset           (reset),
        .we              (cp0_we),
        .waddr           (wb.addr[4:0]),
        .wdata           (wb.data),
        .raddr           (raddr_2[4:0]),
        .rdata           (cp0_rdata),
        .exc             (exc),
        .eret            (eret),
        .hw_int          (hw_int),
        .view            (cp0_out),
        .allow_interrupt (allow_interrupt)
    );

    // port 1, cp0 hidden
    operand_read #(
        .CP0_VISIBLE (1'b0)
    ) operand_read_1_inst (
        .raddr    (raddr_1),
        .region   (rd_region_1),
        .wb       (wb),
        .hilo_wr  (hilo_wr),
        .gpr_data (gpr_rdata_1),
        .hi       (hi_q),
        .lo       (lo_q),
        .cp0_data (cp0_rdata),
        .rdata    (rdata_1)
    );

    // port 2, cp0 visible
    operand_read #(
        .CP0_VISIBLE (1'b1)
    ) operand_read_2_inst (
        .raddr    (raddr_2),
        .region   (rd_region_2),
        .wb       (wb),
        .hilo_wr  (hilo_wr),
        .gpr_data (gpr_rdata_2),
        .hi       (hi_q),
        .lo       (lo_q),
        .cp0_data (cp0_rdata),
        .rdata    (rdata_2)
    );

endmodule

`default_nettype wire

/* verif/mips_regs_top_assert.sv */
`timescale 1ns/10ps
`default_nettype none

module mips_regs_top_assert (
    input logic                 clk,
    input logic                 reset,
    input regs_pkg::exc_event_t exc,
    input regs_pkg::reg_addr_t  raddr_1,
    input regs_pkg::reg_addr_t  raddr_2,
    input logic [31:0]          rdata_1,
    input logic [31:0]          rdata_2,
    input regs_pkg::cp0_view_t  cp0_out,
    input logic                 allow_interrupt
);

    // status and cause are back at reset values one edge into reset
    reset_allow_low: assert property (@(posedge clk) reset |=> !allow_interrupt)
        else $error("allow_interrupt is high after a reset cycle");

    // r0 reads zero on port 1, never forwarded
    r0_zero_port_1: assert property (@(posedge clk) (raddr_1 == 7'd0) |-> (rdata_1 == 32'd0))
        else $error("port 1 returned a nonzero value for r0");

    // same for port 2
    r0_zero_port_2: assert property (@(posedge clk) (raddr_2 == 7'd0) |-> (rdata_2 == 32'd0))
        else $error("port 2 returned a nonzero value for r0");

    // exl set by any committed exception
    exc_sets_exl: assert property (@(posedge clk) disable iff (reset)
        exc.valid |=> cp0_out.status[1])
        else $error("status EXL not set in the cycle after an exception");

endmodule

bind mips_regs_top mips_regs_top_assert mips_regs_top_assert_inst (
    .clk             (clk),
    .reset           (reset),
    .exc             (exc),
    .raddr_1         (raddr_1),
    .raddr_2         (raddr_2),
    .rdata_1         (rdata_1),
    .rdata_2         (rdata_2),
    .cp0_out         (cp0_out),
    .allow_interrupt (allow_interrupt)
);

`default_nettype wire

/* verif/mips_regs_top_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module mips_regs_top_tb;
    import regs_pkg::*;

    localparam logic [31:0] STATUS_RESET = 32'h1040_0000;
    localparam logic [31:0] PRID_VALUE   = 32'h0001_8001;
    localparam wb_write_t   NO_WB  = '0;
    localparam hilo_write_t NO_HL  = '0;
    localparam exc_event_t  NO_EXC = '0;

    // one table row, stimulus then expected
    typedef struct packed {
        wb_write_t   wb;
        hilo_write_t hl;
        exc_event_t  exc;
        logic        eret;
        logic [5:0]  hw_int;
        reg_addr_t   ra1;
        reg_addr_t   ra2;
        logic [31:0] exp_rd1;
        logic [31:0] exp_rd2;
        cp0_view_t   exp_cp0;
        logic        exp_allow;
    } row_t;

    logic        clk;
    logic        reset;
    wb_write_t   wb;
    hilo_write_t hilo_wr;
    exc_event_t  exc;
    logic        eret;
    logic [5:0]  hw_int;
    reg_addr_t   raddr_1;
    reg_addr_t   raddr_2;
    logic [31:0] rdata_1;
    logic [31:0] rdata_2;
    cp0_view_t   cp0_out;
    logic        allow_interrupt;

    row_t        rows[$];
    int          errors = 0;
    int          checks = 0;
    int          cycles = 0;
    int          cycle_limit = 1000;
    logic [31:0] seed = 32'h5f49;

    // reference state
    logic [31:0] model_gpr [0:31];
    logic [31:0] model_hi;
    logic [31:0] model_lo;
    logic [31:0] model_status;
    logic [31:0] model_cause;
    logic [31:0] model_epc;
    logic [31:0] model_badv;

    mips_regs_top #(
        .STATUS_RESET (STATUS_RESET),
        .PRID_VALUE   (PRID_VALUE)
    ) mips_regs_top_inst (
        .clk             (clk),
        .reset           (reset),
        .wb              (wb),
        .hilo_wr         (hilo_wr),
        .exc             (exc),
        .eret            (eret),
        .hw_int          (hw_int),
        .raddr_1         (raddr_1),
        .raddr_2         (raddr_2),
        .rdata_1         (rdata_1),
        .rdata_2         (rdata_2),
        .cp0_out         (cp0_out),
        .allow_interrupt (allow_interrupt)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // run limit, rows plus reset plus margin
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("timeout after %0d cycles, the table did not finish", cycles);
            $display("=== FAIL ===");
            $finish;
        end
    end

    function logic [31:0] lcg_next();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    function automatic wb_write_t wb_word(input reg_addr_t a, input logic [31:0] d);
        return '{en: 1'b1, addr: a, data: d};
    endfunction

    function automatic hilo_write_t bulk_pair(input logic [31:0] h, input logic [31:0] l);
        return '{en: 1'b1, hi: h, lo: l};
    endfunction

    function automatic exc_event_t exception_of(input exc_code_e code, input logic [31:0] pc,
                                                input logic [31:0] bad, input logic bd);
        return '{valid: 1'b1, code: code, epc: pc, badaddr: bad, branch_delay: bd};
    endfunction

    task automatic push_row(input wb_write_t w, input hilo_write_t h, input exc_event_t e,
                            input logic er, input logic [5:0] irq,
                            input reg_addr_t a1, input reg_addr_t a2);
        row_t r;
        r = '0;
        r.wb = w;
        r.hl = h;
        r.exc = e;
        r.eret = er;
        r.hw_int = irq;
        r.ra1 = a1;
        r.ra2 = a2;
        rows.push_back(r);
    endtask

    // stored cp0 word by register number
    function automatic logic [31:0] cp0_word(input logic [4:0] sel);
        case (sel)
            5'd8:    return model_badv;
            5'd12:   return model_status;
            5'd13:   return model_cause;
            5'd14:   return model_epc;
            5'd15:   return PRID_VALUE;
            default: return 32'd0;
        endcase
    endfunction

    // forwarding first, then stored state by address range
    function automatic logic [31:0] predict_read(input reg_addr_t a, input bit cp0_port,
                                                 input row_t r);
        if (r.wb.en && r.wb.addr == a && a != 7'd0) begin
            return r.wb.data;
        end else if (r.hl.en && a == 7'd127) begin
            return r.hl.hi;
        end else if (r.hl.en && a == 7'd64) begin
            return r.hl.lo;
        end else if (a < 7'd32) begin
            return model_gpr[a[4:0]];
        end else if (a < 7'd64) begin
            return cp0_port ? cp0_word(a[4:0]) : 32'd0;
        end else if (a == 7'd127) begin
            return model_hi;
        end
        // 64 and the empty 65-126 give lo
        return model_lo;
    endfunction

    // some ip line pending and unmasked
    // ie set and exl clear
    function automatic logic interrupt_allowed();
        logic pending;
        pending = 1'b0;
        for (int b = 8; b < 16; b++) begin
            if (model_cause[b] && model_status[b]) begin
                pending = 1'b1;
            end
        end
        return pending && model_status[0] && !model_status[1];
    endfunction

    // state after the clock edge
    task automatic model_commit(input row_t r);
        logic       mtc0;
        logic [4:0] sel;
        mtc0 = r.wb.en && r.wb.addr >= 7'd32 && r.wb.addr < 7'd64;
        sel = r.wb.addr[4:0];
        if (r.wb.en && r.wb.addr < 7'd32 && r.wb.addr != 7'd0) begin
            model_gpr[sel] = r.wb.data;
        end
        // bulk beats single word
        if (r.hl.en) begin
            model_hi = r.hl.hi;
            model_lo = r.hl.lo;
        end else if (r.wb.en && r.wb.addr == 7'd127) begin
            model_hi = r.wb.data;
        end else if (r.wb.en && r.wb.addr == 7'd64) begin
            model_lo = r.wb.data;
        end
        // writable status bits im, exl, ie
        if (r.exc.valid) begin
            model_status[1] = 1'b1;
        end else if (r.eret) begin
            model_status[1] = 1'b0;
        end else if (mtc0 && sel == 5'd12) begin
            model_status[15:8] = r.wb.data[15:8];
            model_status[1:0] = r.wb.data[1:0];
        end
        model_cause[15:10] = r.hw_int;
        if (r.exc.valid) begin
            model_cause[31] = r.exc.branch_delay;
            model_cause[6:2] = r.exc.code;
        end else if (mtc0 && sel == 5'd13) begin
            model_cause[9:8] = r.wb.data[9:8];
        end
        if (r.exc.valid) begin
            model_epc = r.exc.epc;
        end else if (mtc0 && sel == 5'd14) begin
            model_epc = r.wb.data;
        end
        // badvaddr only on address errors
        if (r.exc.valid && (r.exc.code == exc_adel || r.exc.code == exc_ades)) begin
            model_badv = r.exc.badaddr;
        end else if (mtc0 && sel == 5'd8) begin
            model_badv = r.wb.data;
        end
    endtask

    task automatic build_table();
        // after reset, status and prid on port 2, port 1 hides cp0
        push_row(NO_WB, NO_HL, NO_EXC, 1'b0, 6'd0, 7'd44, 7'd44);
        push_row(NO_WB, NO_HL, NO_EXC, 1'b0, 6'd0, 7'd64, 7'd47);
        // fill r1..r31, forward on port 1, previous one stored on port 2
        for (int i = 1; i < 32; i++) begin
            push_row(wb_word(7'(i), lcg_next()), NO_HL, NO_EXC, 1'b0, 6'd0, 7'(i), 7'(i - 1));
        end
        // r0 write is dropped and not forwarded
        push_row(wb_word(7'd0, lcg_next()), NO_HL, NO_EXC, 1'b0, 6'd0, 7'd0, 7'd0);
        push_row(wb_word(7'd5, lcg_next()), NO_HL, NO_EXC, 1'b0, 6'd0, 7'd5, 7'd5);
        for (int k = 0; k < 16; k++) begin
            push_row(NO_WB, NO_HL, NO_EXC, 1'b0, 6'd0, 7'(2 * k + 1), 7'(2 * k + 2));
        end
        // hi/lo single words, bulk, bulk against mthi
        push_row(wb_word(7'd64, lcg_next()), NO_HL, NO_EXC, 1'b0, 6'd0, 7'd64, 7'd64);
        push_row(wb_word(7'd127, lcg_next()), NO_HL, NO_EXC, 1'b0, 6'd0, 7'd127, 7'd64);
        push_row(NO_WB, NO_HL, NO_EXC, 1'b0, 6'd0, 7'd64, 7'd127);
        push_row(NO_WB, bulk_pair(lcg_next(), lcg_next()), NO_EXC, 1'b0, 6'd0, 7'd127, 7'd64);
        push_row(NO_WB, NO_HL, NO_EXC, 1'b0, 6'd0, 7'd127, 7'd64);
        push_row(wb_word(7'd127, lcg_next()), bulk_pair(lcg_next(), lcg_next()), NO_EXC,
                 1'b0, 6'd0, 7'd127, 7'd64);
        push_row(NO_WB, NO_HL, NO_EXC, 1'b0, 6'd0, 7'd127, 7'd64);
        push_row(NO_WB, NO_HL, NO_EXC, 1'b0, 6'd0, 7'd100, 7'd127);
        // status im/exl/ie, prid stays read-only
        push_row(wb_word(7'd44, 32'hf0f0_ff01), NO_HL, NO_EXC, 1'b0, 6'd0, 7'd0, 7'd0);
        push_row(NO_WB, NO_HL, NO_EXC, 1'b0, 6'd0, 7'd44, 7'd44);
        push_row(wb_word(7'd47, lcg_next()), NO_HL, NO_EXC, 1'b0, 6'd0, 7'd0, 7'd0);
        push_row(NO_WB, NO_HL, NO_EXC, 1'b0, 6'd0, 7'd44, 7'd47);
        // epc and badvaddr by mtc0
        push_row(wb_word(7'd46, lcg_next()), NO_HL, NO_EXC, 1'b0, 6'd0, 7'd0, 7'd40);
        push_row(wb_word(7'd40, lcg_next()), NO_HL, NO_EXC, 1'b0, 6'd0, 7'd46, 7'd46);
        push_row(NO_WB, NO_HL, NO_EXC, 1'b0, 6'd0, 7'd40, 7'd40);
        // interrupts, only im2 unmasked
        push_row(wb_word(7'd44, 32'h0000_0401), NO_HL, NO_EXC, 1'b0, 6'd0, 7'd0, 7'd44);
        push_row(NO_WB, NO_HL, NO_EXC, 1'b0, 6'b000010, 7'd0, 7'd45);
        push_row(NO_WB, NO_HL, NO_EXC, 1'b0, 6'b000001, 7'd0, 7'd45);
        push_row(wb_word(7'd44, 32'h0000_0400), NO_HL, NO_EXC, 1'b0, 6'b000001, 7'd0, 7'd45);
        push_row(wb_word(7'd44, 32'h0000_0401), NO_HL, NO_EXC, 1'b0, 6'b000001, 7'd0, 7'd44);
        // exceptions, mtc0 epc loses, sys keeps badvaddr
        push_row(wb_word(7'd46, lcg_next()), NO_HL,
                 exception_of(exc_adel, lcg_next(), lcg_next(), 1'b1),
                 1'b0, 6'b000001, 7'd0, 7'd46);
        push_row(NO_WB, NO_HL, NO_EXC, 1'b0, 6'b000001, 7'd46, 7'd46);
        push_row(NO_WB, NO_HL, NO_EXC, 1'b0, 6'b000001, 7'd0, 7'd40);
        push_row(NO_WB, NO_HL, NO_EXC, 1'b0, 6'b000001, 7'd0, 7'd45);
        push_row(NO_WB, NO_HL, exception_of(exc_sys, lcg_next(), lcg_next(), 1'b0),
                 1'b0, 6'b000001, 7'd0, 7'd40);
        push_row(NO_WB, NO_HL, NO_EXC, 1'b0, 6'b000001, 7'd45, 7'd40);
        push_row(NO_WB, NO_HL, NO_EXC, 1'b1, 6'b000001, 7'd0, 7'd44);
        // eret with exception, exception wins
        push_row(NO_WB, NO_HL, exception_of(exc_ov, lcg_next(), lcg_next(), 1'b0),
                 1'b1, 6'b000001, 7'd0, 7'd44);
        push_row(NO_WB, NO_HL, NO_EXC, 1'b1, 6'b000001, 7'd0, 7'd44);
        // software ip bits only
        push_row(wb_word(7'd45, 32'hffff_ffff), NO_HL, NO_EXC, 1'b0, 6'b000001, 7'd0, 7'd45);
        push_row(NO_WB, NO_HL, NO_EXC, 1'b0, 6'd0, 7'd0, 7'd45);
    endtask

    // run the model over the table once, fill expected columns
    task automatic predict_table();
        row_t r;
        for (int i = 0; i < 32; i++) begin
            model_gpr[i] = 32'd0;
        end
        model_hi = 32'd0;
        model_lo = 32'd0;
        model_status = STATUS_RESET;
        model_cause = 32'd0;
        model_epc = 32'd0;
        model_badv = 32'd0;
        foreach (rows[i]) begin
            r = rows[i];
            r.exp_rd1 = predict_read(r.ra1, 1'b0, r);
            r.exp_rd2 = predict_read(r.ra2, 1'b1, r);
            model_commit(r);
            r.exp_cp0 = '{status: model_status, cause: model_cause, epc: model_epc};
            r.exp_allow = interrupt_allowed();
            rows[i] = r;
        end
    endtask

    task automatic compare_word(input string name, input logic [31:0] got,
                                input logic [31:0] expected);
        checks++;
        assert (got === expected) else begin
            errors++;
            $display("Fail at %0t: %s expected %h, got %h", $time, name, expected, got);
        end
    endtask

    task automatic drive_row(input row_t r);
        wb = r.wb;
        hilo_wr = r.hl;
        exc = r.exc;
        eret = r.eret;
        hw_int = r.hw_int;
        raddr_1 = r.ra1;
        raddr_2 = r.ra2;
    endtask

    initial begin
        reset = 1'b1;
        wb = NO_WB;
        hilo_wr = NO_HL;
        exc = NO_EXC;
        eret = 1'b0;
        hw_int = 6'd0;
        raddr_1 = 7'd0;
        raddr_2 = 7'd0;
        build_table();
        predict_table();
        cycle_limit = rows.size() + 8 + 50;
        repeat (8) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        // reset values
        compare_word("cp0_out.status", cp0_out.status, STATUS_RESET);
        compare_word("cp0_out.cause", cp0_out.cause, 32'd0);
        compare_word("cp0_out.epc", cp0_out.epc, 32'd0);
        compare_word("allow_interrupt", {31'd0, allow_interrupt}, 32'd0);
        foreach (rows[i]) begin
            drive_row(rows[i]);
            // same-cycle reads, before the edge
            #2;
            compare_word("rdata_1", rdata_1, rows[i].exp_rd1);
            compare_word("rdata_2", rdata_2, rows[i].exp_rd2);
            @(negedge clk);
            // registered state after the edge
            compare_word("cp0_out.status", cp0_out.status, rows[i].exp_cp0.status);
            compare_word("cp0_out.cause", cp0_out.cause, rows[i].exp_cp0.cause);
            compare_word("cp0_out.epc", cp0_out.epc, rows[i].exp_cp0.epc);
            compare_word("allow_interrupt", {31'd0, allow_interrupt},
                         {31'd0, rows[i].exp_allow});
        end
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* mips_regs_top.f */
logic/regs_pkg.sv
logic/gpr_bank.sv
logic/hilo_regs.sv
logic/cp0_regs.sv
logic/operand_read.sv
logic/mips_regs_top.sv
verif/mips_regs_top_assert.sv
verif/mips_regs_top_tb.sv

/* Bender.yml */
package:
  name: mips_regs

sources:
  - logic/regs_pkg.sv
  - logic/gpr_bank.sv
  - logic/hilo_regs.sv
  - logic/cp0_regs.sv
  - logic/operand_read.sv
  - logic/mips_regs_top.sv
  - target: test
    files:
      - verif/mips_regs_top_assert.sv
      - verif/mips_regs_top_tb.sv
